//--- flist.f
+incdir+hw
hw/mem_ctrl_pkg.sv
hw/axi_chan_pkg.sv
hw/mem_beat_counter.sv
hw/mem_wr_fsm.sv
hw/mem_rd_fsm.sv
hw/mem_line_store.sv
hw/mem_bresp_queue.sv
hw/mem_axi_top.sv
dv/mem_axi_props.sv
dv/mem_axi_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then decide pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_axi_tb -f flist.f \
	&& { ./obj_dir/Vmem_axi_tb > sim.log 2>&1 || true; } \
	|| { echo "verilator build failed"; exit 1; }

cat sim.log
grep -q "PASS: all tests" sim.log && exit 0 || exit 1

//--- dv/mem_axi_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_axi_tb;

	// directed and random transactions, about 30 cycles each at worst
	localparam int N_DIRECTED     = 20;
	localparam int N_RANDOM       = 80;
	localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 30;

	logic                  clk;
	logic                  rst_n;
	axi_chan_pkg::aw_req_t aw;
	logic                  aw_valid;
	logic                  aw_ready;
	axi_chan_pkg::w_beat_t w;
	logic                  w_valid;
	logic                  w_ready;
	axi_chan_pkg::b_rsp_t  b;
	logic                  b_valid;
	logic                  b_ready;
	axi_chan_pkg::ar_req_t ar;
	logic                  ar_valid;
	logic                  ar_ready;
	axi_chan_pkg::r_beat_t r;
	logic                  r_valid;
	logic                  r_ready;

	// byte-level reference of the storage
	logic [`MEM_DATA_W-1:0] ref_mem [`MEM_LINES][`MEM_BEATS] = '{default: '0};
	logic [`MEM_ID_W-1:0]   exp_bid [$];
	int                     errors = 0;
	int                     cycles = 0;

	mem_axi_top dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.b        (b),
		.b_valid  (b_valid),
		.b_ready  (b_ready),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// only strobed bytes take the new value
	function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
			input logic [63:0] new_word, input logic [7:0] strb);
		logic [63:0] res;
		res = old_word;
		for (int k = 0; k < `MEM_STRB_W; k++) begin
			if (strb[k]) res[k*8 +: 8] = new_word[k*8 +: 8];
		end
		return res;
	endfunction

	task automatic write_burst(input logic [3:0] id, input logic [3:0] line, input logic len,
			input logic [63:0] d0, input logic [7:0] s0,
			input logic [63:0] d1, input logic [7:0] s1);
		@(posedge clk);
		#5;
		aw = '{id: id, line: line, len: len};
		aw_valid = 1'b1;
		do @(negedge clk); while (!aw_ready);
		@(posedge clk);
		#5;
		aw_valid = 1'b0;
		exp_bid.push_back(id);
		for (int i = 0; i <= int'(len); i++) begin
			w = '{data: (i == 0) ? d0 : d1, strb: (i == 0) ? s0 : s1};
			w_valid = 1'b1;
			do @(negedge clk); while (!w_ready);
			@(posedge clk);
			#5;
			ref_mem[line][i] = merge_bytes(ref_mem[line][i], w.data, w.strb);
		end
		w_valid = 1'b0;
	endtask

	task automatic read_burst(input string name, input logic [3:0] id, input logic [3:0] line,
			input logic len, input bit stall);
		int beat;
		@(posedge clk);
		#5;
		ar = '{id: id, line: line, len: len};
		ar_valid = 1'b1;
		do @(negedge clk); while (!ar_ready);
		@(posedge clk);
		#5;
		ar_valid = 1'b0;
		beat = 0;
		while (beat <= int'(len)) begin
			r_ready = stall ? 1'($urandom_range(1)) : 1'b1;
			@(negedge clk);
			if (r_valid && r_ready) begin
				check_value({name, " data"}, ref_mem[line][beat], r.data);
				check_value({name, " rid"}, 64'(id), 64'(r.id));
				check_value({name, " rlast"}, 64'(beat == int'(len)), 64'(r.last));
				beat++;
			end
			@(posedge clk);
			#5;
		end
		r_ready = 1'b0;
	endtask

	task automatic drain_bresp();
		while (exp_bid.size() != 0) @(posedge clk);
	endtask

	// B channel monitor, responses must follow write order
	always @(negedge clk) begin
		if (rst_n && b_valid && b_ready) begin
			if (exp_bid.size() == 0) begin
				errors++;
				$display("write response with id %h arrived with no write outstanding", b.id);
			end else begin
				check_value("bid order", 64'(exp_bid.pop_front()), 64'(b.id));
			end
		end
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT stopped answering a handshake", cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		logic [3:0] id_r;
		logic [3:0] line_r;
		logic       len_r;
		void'($urandom(32'h0438_8b84));
		rst_n    = 1'b0;
		aw       = '0;
		aw_valid = 1'b0;
		w        = '0;
		w_valid  = 1'b0;
		b_ready  = 1'b1;
		ar       = '0;
		ar_valid = 1'b0;
		r_ready  = 1'b0;
		repeat (10) @(posedge clk);
		#5;
		rst_n = 1'b1;

		// handshake outputs out of reset
		@(negedge clk);
		check_value("reset awready", 64'h1, 64'(aw_ready));
		check_value("reset arready", 64'h1, 64'(ar_ready));
		check_value("reset wready", 64'h0, 64'(w_ready));
		check_value("reset bvalid", 64'h0, 64'(b_valid));
		check_value("reset rvalid", 64'h0, 64'(r_valid));

		// unwritten lines read as zero
		read_burst("unwritten two-beat", 4'h3, 4'h9, 1'b1, 1'b0);
		read_burst("unwritten one-beat", 4'h6, 4'h2, 1'b0, 1'b0);

		write_burst(4'h1, 4'h5, 1'b1, 64'h0123_4567_89ab_cdef, 8'hff,
			64'hfedc_ba98_7654_3210, 8'hff);
		read_burst("full strobe", 4'h1, 4'h5, 1'b1, 1'b0);

		write_burst(4'h2, 4'h5, 1'b1, {$urandom, $urandom}, 8'($urandom),
			{$urandom, $urandom}, 8'($urandom));
		read_burst("random strobe", 4'h2, 4'h5, 1'b1, 1'b0);

		// fill the response queue with bready low
		drain_bresp();
		@(posedge clk);
		#5;
		b_ready = 1'b0;
		for (int k = 0; k < `MEM_BQ_DEPTH; k++) begin
			write_burst(4'(4'ha + k), 4'(k), 1'(k % 2), {$urandom, $urandom}, 8'hff,
				{$urandom, $urandom}, 8'hff);
		end
		repeat (4) begin
			@(negedge clk);
			check_value("bvalid hold", 64'h1, 64'(b_valid));
			check_value("bid hold", 64'ha, 64'(b.id));
			check_value("awready while queue full", 64'h0, 64'(aw_ready));
		end
		@(posedge clk);
		#5;
		b_ready = 1'b1;
		drain_bresp();

		for (int i = 0; i < 8; i++) begin
			read_burst("rready stall", 4'(i), 4'(i), 1'b1, 1'b1);
		end

		// mixed traffic over all lines
		for (int n = 0; n < N_RANDOM; n++) begin
			id_r   = 4'($urandom_range(15));
			line_r = 4'($urandom_range(15));
			len_r  = 1'($urandom_range(1));
			if ($urandom_range(1) == 1) begin
				write_burst(id_r, line_r, len_r, {$urandom, $urandom}, 8'($urandom),
					{$urandom, $urandom}, 8'($urandom));
			end else begin
				read_burst("mixed traffic", id_r, line_r, len_r, 1'b1);
			end
		end
		drain_bresp();

		$display("errors: %0d check failures, %0d assertion failures",
			errors, dut0.u_props.fail_cnt);
		if (errors == 0 && dut0.u_props.fail_cnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/mem_axi_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_axi_props (
	input wire                        clk,
	input wire                        rst_n,
	input wire axi_chan_pkg::aw_req_t aw,
	input wire                        aw_valid,
	input wire                        aw_ready,
	input wire axi_chan_pkg::w_beat_t w,
	input wire                        w_valid,
	input wire                        w_ready,
	input wire axi_chan_pkg::b_rsp_t  b,
	input wire                        b_valid,
	input wire                        b_ready,
	input wire axi_chan_pkg::ar_req_t ar,
	input wire                        ar_valid,
	input wire                        ar_ready,
	input wire axi_chan_pkg::r_beat_t r,
	input wire                        r_valid,
	input wire                        r_ready
);

	mem_ctrl_pkg::beat_idx_t r_beat;
	mem_ctrl_pkg::beat_idx_t r_len;
	logic [3:0]              wr_pending;
	int                      fail_cnt = 0;

	// beat on R and writes accepted but not yet answered
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			r_beat     <= '0;
			r_len      <= '0;
			wr_pending <= '0;
		end else begin
			if (ar_valid && ar_ready) begin
				r_beat <= '0;
				r_len  <= ar.len;
			end else if (r_valid && r_ready) begin
				r_beat <= mem_ctrl_pkg::beat_idx_t'(r_beat + 1'b1);
			end
			wr_pending <= wr_pending + 4'(aw_valid && aw_ready) - 4'(b_valid && b_ready);
		end
	end

	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else begin
			$error("aw payload dropped or changed before aw_ready");
			fail_cnt++;
		end

	w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else begin
			$error("w payload dropped or changed before w_ready");
			fail_cnt++;
		end

	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			$error("ar payload dropped or changed before ar_ready");
			fail_cnt++;
		end

	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else begin
			$error("b response dropped or changed before b_ready");
			fail_cnt++;
		end

	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else begin
			$error("r beat dropped or changed before r_ready");
			fail_cnt++;
		end

	// last only on the final beat of the burst
	r_last_final: assert property (@(posedge clk) disable iff (!rst_n)
		r_valid |-> (r.last == (r_beat == r_len)))
		else begin
			$error("rlast does not match the final beat of the burst");
			fail_cnt++;
		end

	b_after_write: assert property (@(posedge clk) disable iff (!rst_n)
		b_valid |-> (wr_pending != '0))
		else begin
			$error("bvalid without an accepted write");
			fail_cnt++;
		end

endmodule

bind mem_axi_top mem_axi_props u_props (.*);

`default_nettype wire

//--- hw/mem_axi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_axi_top (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire axi_chan_pkg::aw_req_t aw,
	input  wire                        aw_valid,
	output logic                       aw_ready,
	input  wire axi_chan_pkg::w_beat_t w,
	input  wire                        w_valid,
	output logic                       w_ready,
	output axi_chan_pkg::b_rsp_t       b,
	output logic                       b_valid,
	input  wire                        b_ready,
	input  wire axi_chan_pkg::ar_req_t ar,
	input  wire                        ar_valid,
	output logic                       ar_ready,
	output axi_chan_pkg::r_beat_t      r,
	output logic                       r_valid,
	input  wire                        r_ready
);

	mem_ctrl_pkg::line_idx_t st_line;
	mem_ctrl_pkg::beat_idx_t st_beat;
	mem_ctrl_pkg::line_idx_t rd_line;
	mem_ctrl_pkg::beat_idx_t rd_beat;
	logic [`MEM_DATA_W-1:0]  st_wdata;
	logic [`MEM_STRB_W-1:0]  st_strb;
	logic [`MEM_DATA_W-1:0]  rd_data;
	logic [`MEM_ID_W-1:0]    bq_id;
	logic                    st_we;
	logic                    bq_push;
	logic                    bq_full;

	mem_wr_fsm u_wr_fsm (
		.clk      (clk),
		.rst_n    (rst_n),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.bq_full  (bq_full),
		.st_we    (st_we),
		.st_line  (st_line),
		.st_beat  (st_beat),
		.st_wdata (st_wdata),
		.st_strb  (st_strb),
		.bq_push  (bq_push),
		.bq_id    (bq_id)
	);

	mem_rd_fsm u_rd_fsm (
		.clk      (clk),
		.rst_n    (rst_n),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.rd_line  (rd_line),
		.rd_beat  (rd_beat),
		.rd_data  (rd_data),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready)
	);

	mem_line_store u_store (
		.clk     (clk),
		.rst_n   (rst_n),
		.we      (st_we),
		.line    (st_line),
		.beat    (st_beat),
		.wdata   (st_wdata),
		.strb    (st_strb),
		.rd_line (rd_line),
		.rd_beat (rd_beat),
		.rd_data (rd_data)
	);

	mem_bresp_queue u_bq (
		.clk     (clk),
		.rst_n   (rst_n),
		.push    (bq_push),
		.id      (bq_id),
		.full    (bq_full),
		.b       (b),
		.b_valid (b_valid),
		.b_ready (b_ready)
	);

endmodule

`default_nettype wire

//--- hw/mem_bresp_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_bresp_queue (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        push,
	input  wire [`MEM_ID_W-1:0]        id,
	output logic                       full,
	output axi_chan_pkg::b_rsp_t       b,
	output logic                       b_valid,
	input  wire                        b_ready
);

	localparam int DEPTH = `MEM_BQ_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	logic [`MEM_ID_W-1:0] fifo [DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [PTR_W:0]       count;
	logic [PTR_W:0]       count_nxt;
	logic                 pop;

	assign b_valid   = (count != '0);
	assign pop       = b_valid & b_ready;
	assign count_nxt = count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);

	// full as seen after this cycle, so a push on the last slot shows at once
	assign full = (count_nxt == (PTR_W+1)'(DEPTH));

	assign b = '{id: fifo[rd_ptr]};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			count <= count_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (push) fifo[wr_ptr] <= id;
	end

endmodule

`default_nettype wire

//--- hw/mem_line_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_line_store (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          we,
	input  wire mem_ctrl_pkg::line_idx_t line,
	input  wire mem_ctrl_pkg::beat_idx_t beat,
	input  wire [`MEM_DATA_W-1:0]        wdata,
	input  wire [`MEM_STRB_W-1:0]        strb,
	input  wire mem_ctrl_pkg::line_idx_t rd_line,
	input  wire mem_ctrl_pkg::beat_idx_t rd_beat,
	output logic [`MEM_DATA_W-1:0]       rd_data
);

	localparam int BYTE_W = `MEM_DATA_W / `MEM_STRB_W;

	logic [`MEM_DATA_W-1:0] mem [`MEM_LINES][`MEM_BEATS];

	// unwritten lines must read as zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem <= '{default: '0};
		end else if (we) begin
			for (int b = 0; b < `MEM_STRB_W; b++) begin
				// only strobed bytes change
				if (strb[b]) begin
					mem[line][beat][b*BYTE_W +: BYTE_W] <= wdata[b*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	assign rd_data = mem[rd_line][rd_beat];

endmodule

`default_nettype wire

//--- hw/mem_rd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_rd_fsm (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire axi_chan_pkg::ar_req_t   ar,
	input  wire                          ar_valid,
	output logic                         ar_ready,
	output mem_ctrl_pkg::line_idx_t      rd_line,
	output mem_ctrl_pkg::beat_idx_t      rd_beat,
	input  wire [`MEM_DATA_W-1:0]        rd_data,
	output axi_chan_pkg::r_beat_t        r,
	output logic                         r_valid,
	input  wire                          r_ready
);

	mem_ctrl_pkg::rd_state_t state;
	mem_ctrl_pkg::line_idx_t line_q;
	mem_ctrl_pkg::beat_idx_t cnt_beat;
	logic [`MEM_ID_W-1:0]    id_q;
	logic [`MEM_DATA_W-1:0]  data_q;
	logic                    cnt_last;
	logic                    ar_fire;
	logic                    r_fire;

	assign ar_ready = (state == mem_ctrl_pkg::RD_IDLE);
	assign r_valid  = (state == mem_ctrl_pkg::RD_BURST);
	assign ar_fire  = ar_valid & ar_ready;
	assign r_fire   = r_valid & r_ready;

	// tracks the beat currently on R
	mem_beat_counter u_beat_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (ar_fire),
		.len   (ar.len),
		.step  (r_fire & ~cnt_last),
		.beat  (cnt_beat),
		.last  (cnt_last)
	);

	// beat 0 straight from the request, later beats one ahead of R
	assign rd_line = ar_ready ? ar.line : line_q;
	assign rd_beat = ar_ready ? '0 : mem_ctrl_pkg::beat_idx_t'(cnt_beat + 1'b1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mem_ctrl_pkg::RD_IDLE;
		end else begin
			case (state)
				mem_ctrl_pkg::RD_IDLE: if (ar_fire) state <= mem_ctrl_pkg::RD_BURST;
				mem_ctrl_pkg::RD_BURST: begin
					if (r_fire && cnt_last) state <= mem_ctrl_pkg::RD_IDLE;
				end
				default: state <= mem_ctrl_pkg::RD_IDLE;
			endcase
		end
	end

	// output register, holds while rready is low
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			id_q   <= ar.id;
			line_q <= ar.line;
			data_q <= rd_data;
		end else if (r_fire && !cnt_last) begin
			data_q <= rd_data;
		end
	end

	assign r = '{id: id_q, data: data_q, last: cnt_last};

endmodule

`default_nettype wire

//--- hw/mem_wr_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_wr_fsm (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire axi_chan_pkg::aw_req_t   aw,
	input  wire                          aw_valid,
	output logic                         aw_ready,
	input  wire axi_chan_pkg::w_beat_t   w,
	input  wire                          w_valid,
	output logic                         w_ready,
	input  wire                          bq_full,
	output logic                         st_we,
	output mem_ctrl_pkg::line_idx_t      st_line,
	output mem_ctrl_pkg::beat_idx_t      st_beat,
	output logic [`MEM_DATA_W-1:0]       st_wdata,
	output logic [`MEM_STRB_W-1:0]       st_strb,
	output logic                         bq_push,
	output logic [`MEM_ID_W-1:0]         bq_id
);

	mem_ctrl_pkg::wr_state_t state;
	mem_ctrl_pkg::line_idx_t line_q;
	logic [`MEM_ID_W-1:0]    id_q;
	logic                    aw_fire;
	logic                    w_fire;
	logic                    cnt_last;

	assign aw_ready = (state == mem_ctrl_pkg::WR_IDLE);
	assign w_ready  = (state == mem_ctrl_pkg::WR_DATA);
	assign aw_fire  = aw_valid & aw_ready;
	assign w_fire   = w_valid & w_ready;

	// beat index of the incoming W beat
	mem_beat_counter u_beat_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (aw_fire),
		.len   (aw.len),
		.step  (w_fire),
		.beat  (st_beat),
		.last  (cnt_last)
	);

	assign st_we    = w_fire;
	assign st_line  = line_q;
	assign st_wdata = w.data;
	assign st_strb  = w.strb;
	assign bq_push  = w_fire & cnt_last;
	assign bq_id    = id_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mem_ctrl_pkg::WR_IDLE;
		end else begin
			case (state)
				mem_ctrl_pkg::WR_IDLE: if (aw_fire) state <= mem_ctrl_pkg::WR_DATA;
				mem_ctrl_pkg::WR_DATA: begin
					// bq_full already counts this push
					if (bq_push) begin
						state <= bq_full ? mem_ctrl_pkg::WR_HOLD : mem_ctrl_pkg::WR_IDLE;
					end
				end
				mem_ctrl_pkg::WR_HOLD: if (!bq_full) state <= mem_ctrl_pkg::WR_IDLE;
				default: state <= mem_ctrl_pkg::WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			id_q   <= aw.id;
			line_q <= aw.line;
		end
	end

endmodule

`default_nettype wire

//--- hw/mem_beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_beat_counter (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          load,
	input  wire mem_ctrl_pkg::beat_idx_t len,
	input  wire                          step,
	output mem_ctrl_pkg::beat_idx_t      beat,
	output logic                         last
);

	mem_ctrl_pkg::beat_idx_t len_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat  <= '0;
			len_q <= '0;
		end else if (load) begin
			// new burst starts at beat 0
			beat  <= '0;
			len_q <= len;
		end else if (step) begin
			beat <= beat + 1'b1;
		end
	end

	assign last = (beat == len_q);

endmodule

`default_nettype wire

//--- hw/axi_chan_pkg.sv
`default_nettype none

`include "mem_config.svh"

package axi_chan_pkg;

	// write address, len holds beats minus one
	typedef struct packed {
		logic [`MEM_ID_W-1:0]    id;
		mem_ctrl_pkg::line_idx_t line;
		mem_ctrl_pkg::beat_idx_t len;
	} aw_req_t;

	// read address carries the same fields
	typedef aw_req_t ar_req_t;

	// write data beat
	typedef struct packed {
		logic [`MEM_DATA_W-1:0] data;
		logic [`MEM_STRB_W-1:0] strb;
	} w_beat_t;

	// write response, always OKAY
	typedef struct packed {
		logic [`MEM_ID_W-1:0] id;
	} b_rsp_t;

	// read data beat
	typedef struct packed {
		logic [`MEM_ID_W-1:0]   id;
		logic [`MEM_DATA_W-1:0] data;
		logic                   last;
	} r_beat_t;

endpackage

`default_nettype wire

//--- hw/mem_ctrl_pkg.sv
`default_nettype none

`include "mem_config.svh"

package mem_ctrl_pkg;

	// line address and beat within a line
	typedef logic [$clog2(`MEM_LINES)-1:0] line_idx_t;
	typedef logic [$clog2(`MEM_BEATS)-1:0] beat_idx_t;

	// write channel: address, data beats, wait for response room
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_DATA,
		WR_HOLD
	} wr_state_t;

	// read channel
	typedef enum logic {
		RD_IDLE,
		RD_BURST
	} rd_state_t;

endpackage

`default_nettype wire

//--- hw/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// data path
`define MEM_DATA_W 64
`define MEM_STRB_W 8

// transaction id
`define MEM_ID_W 4

// storage geometry
`define MEM_LINES 16
`define MEM_BEATS 2

// write responses that may wait for bready
`define MEM_BQ_DEPTH 4

`endif
